// ==== logic/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    localparam int axil_addr_w = 8;                   // byte address
    localparam int axil_data_w = 32;
    localparam int axil_strb_w = axil_data_w / 8;     // one strobe per byte

    // register map, word aligned
    localparam logic [axil_addr_w-1:0] addr_chan0 = 8'h00;
    localparam logic [axil_addr_w-1:0] addr_chan1 = 8'h04;
    localparam logic [axil_addr_w-1:0] addr_chan2 = 8'h08;
    localparam logic [axil_addr_w-1:0] addr_chan3 = 8'h0C;
    localparam logic [axil_addr_w-1:0] addr_ctrl  = 8'h10;    // bit 0 mute

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;   // unmapped address

endpackage

`default_nettype wire

// ==== logic/synth_pkg.sv ====
`default_nettype none

package synth_pkg;

    localparam int sample_w   = 16;               // signed pcm sample
    localparam int num_chan   = 4;                // tone channels
    localparam int phase_w    = 20;               // accumulator width
    localparam int frame_clks = 256;              // clk cycles per sample
    localparam int amp_w      = sample_w - 1;     // magnitude, sign added later
    localparam int fnum_w     = 15;               // phase step per sample

    localparam logic wave_square = 1'b0;          // 50 % duty
    localparam logic wave_pulse  = 1'b1;          // 25 % duty

    typedef struct packed {
        logic              key_on;                // bit 31
        logic              wave;                  // bit 30
        logic [amp_w-1:0]  amp;                   // bits 29:15
        logic [fnum_w-1:0] fnum;                  // bits 14:0
    } chan_reg_t;

    // bus side sees raw, tone side sees fields
    typedef union packed {
        logic [31:0] raw;
        chan_reg_t   fld;
    } chan_reg_u;

endpackage

`default_nettype wire

// ==== logic/chan_cfg_if.sv ====
`default_nettype none

// static per-channel settings, no handshake
interface chan_cfg_if;
    import synth_pkg::*;

    logic              key_on [num_chan];     // channel enabled
    logic              wave   [num_chan];     // square or pulse
    logic [amp_w-1:0]  amp    [num_chan];     // output magnitude
    logic [fnum_w-1:0] fnum   [num_chan];     // phase increment

    modport regs (
        output key_on,
        output wave,
        output amp,
        output fnum
    );

    modport tone (
        input key_on,
        input wave,
        input amp,
        input fnum
    );

endinterface

`default_nettype wire

// ==== logic/axil_regs.sv ====
`default_nettype none

module axil_regs (
    input  wire                                clk,
    input  wire                                arst_n,
    input  wire  [bus_pkg::axil_addr_w-1:0]    awaddr,
    input  wire                                awvalid,
    output logic                               awready,
    input  wire  [bus_pkg::axil_data_w-1:0]    wdata,
    input  wire  [bus_pkg::axil_strb_w-1:0]    wstrb,
    input  wire                                wvalid,
    output logic                               wready,
    output logic [1:0]                         bresp,
    output logic                               bvalid,
    input  wire                                bready,
    input  wire  [bus_pkg::axil_addr_w-1:0]    araddr,
    input  wire                                arvalid,
    output logic                               arready,
    output logic [bus_pkg::axil_data_w-1:0]    rdata,
    output logic [1:0]                         rresp,
    output logic                               rvalid,
    input  wire                                rready,
    output logic                               mute,
    chan_cfg_if.regs                           cfg
);
    import bus_pkg::*;
    import synth_pkg::*;

    chan_reg_u              chan_q [num_chan];    // channel words
    logic [axil_data_w-1:0] ctrl_q;               // control word
    logic [2:0]             wsel;                 // decoded write target
    logic [2:0]             rsel;                 // decoded read target
    logic                   wr_fire;
    logic                   rd_fire;
    logic [axil_data_w-1:0] rd_word;

    // 0..3 channel, 4 control, 7 unmapped
    function automatic logic [2:0] addr_sel(input logic [axil_addr_w-1:0] a);
        case (a)
            addr_chan0: return 3'd0;
            addr_chan1: return 3'd1;
            addr_chan2: return 3'd2;
            addr_chan3: return 3'd3;
            addr_ctrl:  return 3'd4;
            default:    return 3'd7;
        endcase
    endfunction

    function automatic logic [axil_data_w-1:0] byte_merge(
        input logic [axil_data_w-1:0] old_w,
        input logic [axil_data_w-1:0] new_w,
        input logic [axil_strb_w-1:0] strb
    );
        logic [axil_data_w-1:0] res;
        res = old_w;
        for (int b = 0; b < axil_strb_w; b++) begin
            if (strb[b])
                res[8*b +: 8] = new_w[8*b +: 8];  // strobed byte only
        end
        return res;
    endfunction

    assign wr_fire = awvalid & awready & wvalid & wready;
    assign rd_fire = arvalid & arready;
    assign wsel    = addr_sel(awaddr);
    assign rsel    = addr_sel(araddr);

    always_comb begin
        rd_word = '0;                                 // unmapped reads zero
        if (rsel < 3'(num_chan))
            rd_word = chan_q[rsel[1:0]].raw;
        else if (rsel == 3'(num_chan))
            rd_word = ctrl_q;
    end

    // write path, aw and w accepted together
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= resp_okay;
            ctrl_q  <= axil_data_w'(1);               // muted out of reset
            for (int i = 0; i < num_chan; i++)
                chan_q[i].raw <= '0;
        end else begin
            awready <= awvalid & wvalid & ~awready & ~bvalid;   // single cycle pulse
            wready  <= awvalid & wvalid & ~awready & ~bvalid;
            if (bvalid && bready)
                bvalid <= 1'b0;
            if (wr_fire) begin
                bvalid <= 1'b1;
                bresp  <= resp_okay;
                if (wsel < 3'(num_chan))
                    chan_q[wsel[1:0]].raw <= byte_merge(chan_q[wsel[1:0]].raw, wdata, wstrb);
                else if (wsel == 3'(num_chan))
                    ctrl_q <= byte_merge(ctrl_q, wdata, wstrb);
                else
                    bresp <= resp_slverr;             // dropped write
            end
        end
    end

    // read path
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= resp_okay;
        end else begin
            arready <= arvalid & ~arready & ~rvalid;  // stall while rvalid waits
            if (rvalid && rready)
                rvalid <= 1'b0;
            if (rd_fire) begin
                rvalid <= 1'b1;
                rdata  <= rd_word;
                rresp  <= (rsel == 3'd7) ? resp_slverr : resp_okay;
            end
        end
    end

    // field view of each word to the tone bank
    always_comb begin
        for (int i = 0; i < num_chan; i++) begin
            cfg.key_on[i] = chan_q[i].fld.key_on;
            cfg.wave[i]   = chan_q[i].fld.wave;
            cfg.amp[i]    = chan_q[i].fld.amp;
            cfg.fnum[i]   = chan_q[i].fld.fnum;
        end
    end

    assign mute = ctrl_q[0];

endmodule

`default_nettype wire

// ==== logic/tone_bank.sv ====
`default_nettype none

module tone_bank (
    input  wire                                    clk,
    input  wire                                    arst_n,
    input  wire                                    sample_tick,
    chan_cfg_if.tone                               cfg,
    output logic signed [synth_pkg::sample_w-1:0]  chan_sample [synth_pkg::num_chan]
);
    import synth_pkg::*;

    logic [phase_w-1:0]         phase_q   [num_chan];   // accumulators
    logic [phase_w-1:0]         phase_nxt [num_chan];   // after this tick
    logic signed [sample_w-1:0] mag       [num_chan];   // +amp
    logic signed [sample_w-1:0] level     [num_chan];   // +amp or -amp
    logic                       pos       [num_chan];   // positive half

    always_comb begin
        for (int i = 0; i < num_chan; i++) begin
            phase_nxt[i] = phase_q[i] + phase_w'(cfg.fnum[i]);    // wraps at 2^20
            mag[i]       = $signed({1'b0, cfg.amp[i]});           // never negative
            case (cfg.wave[i])
                wave_square: pos[i] = ~phase_nxt[i][phase_w-1];
                wave_pulse:  pos[i] = (phase_nxt[i][phase_w-1 -: 2] == 2'b00);
                default:     pos[i] = 1'b1;
            endcase
            level[i] = pos[i] ? mag[i] : -mag[i];
        end
    end

    // settings are only looked at on the tick
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_chan; i++) begin
                phase_q[i]     <= '0;
                chan_sample[i] <= '0;
            end
        end else if (sample_tick) begin
            for (int i = 0; i < num_chan; i++) begin
                if (cfg.key_on[i]) begin
                    phase_q[i]     <= phase_nxt[i];
                    chan_sample[i] <= level[i];
                end else begin
                    phase_q[i]     <= '0;         // restart phase on next key on
                    chan_sample[i] <= '0;         // silent
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/mix_clamp.sv ====
`default_nettype none

module mix_clamp (
    input  wire                                    clk,
    input  wire                                    arst_n,
    input  wire  signed [synth_pkg::sample_w-1:0]  chan_sample [synth_pkg::num_chan],
    output logic signed [synth_pkg::sample_w-1:0]  left,
    output logic signed [synth_pkg::sample_w-1:0]  right
);
    import synth_pkg::*;

    logic signed [sample_w:0] sum_l;      // ch0 + ch1, one bit headroom
    logic signed [sample_w:0] sum_r;      // ch2 + ch3

    // top two bits differ means out of 16 bit range
    function automatic logic signed [sample_w-1:0] sat(input logic signed [sample_w:0] s);
        if (s[sample_w] != s[sample_w-1])
            return {s[sample_w], {(sample_w-1){~s[sample_w]}}};   // 7fff or 8000
        return s[sample_w-1:0];
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sum_l <= '0;
            sum_r <= '0;
            left  <= '0;
            right <= '0;
        end else begin
            sum_l <= (sample_w+1)'(chan_sample[0]) + (sample_w+1)'(chan_sample[1]);
            sum_r <= (sample_w+1)'(chan_sample[2]) + (sample_w+1)'(chan_sample[3]);
            left  <= sat(sum_l);          // second stage
            right <= sat(sum_r);
        end
    end

endmodule

`default_nettype wire

// ==== logic/i2s_tx.sv ====
`default_nettype none

module i2s_tx (
    input  wire                                    clk,
    input  wire                                    arst_n,
    input  wire  signed [synth_pkg::sample_w-1:0]  left,
    input  wire  signed [synth_pkg::sample_w-1:0]  right,
    input  wire                                    mute,
    output logic                                   sclk,
    output logic                                   ws,
    output logic                                   sd,
    output logic                                   sample_tick
);
    import synth_pkg::*;

    logic [$clog2(frame_clks)-1:0] cnt;           // clk position in frame
    logic [$clog2(frame_clks)-1:0] cnt_nxt;
    logic [sample_w-1:0]           lat_l;         // held for next frame
    logic [sample_w-1:0]           lat_r;
    logic [frame_clks/4-1:0]       shreg;         // 64 slots, left word first
    logic                          slot_end;      // sclk falls next edge

    assign cnt_nxt  = cnt + 1'b1;
    assign slot_end = (cnt[1:0] == 2'b11);
    assign sclk     = cnt[1];                     // clk / 4

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt         <= '0;
            sample_tick <= 1'b0;
            ws          <= 1'b0;
            sd          <= 1'b0;
            lat_l       <= '0;
            lat_r       <= '0;
            shreg       <= '0;
        end else begin
            cnt         <= cnt_nxt;
            sample_tick <= (cnt_nxt == '0);       // high while cnt is 0
            if (cnt == $clog2(frame_clks)'(8)) begin  // mixer output settled by now
                lat_l <= mute ? '0 : left;
                lat_r <= mute ? '0 : right;
            end
            if (slot_end) begin
                ws <= cnt_nxt[$high(cnt)];        // high for right half
                if (cnt_nxt == '0) begin
                    shreg <= {lat_l, {(frame_clks/8-sample_w){1'b0}},
                              lat_r, {(frame_clks/8-sample_w){1'b0}}};
                    sd    <= 1'b0;                // slot 0, one bit ahead of msb
                end else begin
                    sd    <= shreg[$high(shreg)]; // msb first
                    shreg <= shreg << 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/synth_top.sv ====
`default_nettype none

module synth_top (
    input  wire                                clk,
    input  wire                                arst_n,
    input  wire  [bus_pkg::axil_addr_w-1:0]    awaddr,
    input  wire                                awvalid,
    output logic                               awready,
    input  wire  [bus_pkg::axil_data_w-1:0]    wdata,
    input  wire  [bus_pkg::axil_strb_w-1:0]    wstrb,
    input  wire                                wvalid,
    output logic                               wready,
    output logic [1:0]                         bresp,
    output logic                               bvalid,
    input  wire                                bready,
    input  wire  [bus_pkg::axil_addr_w-1:0]    araddr,
    input  wire                                arvalid,
    output logic                               arready,
    output logic [bus_pkg::axil_data_w-1:0]    rdata,
    output logic [1:0]                         rresp,
    output logic                               rvalid,
    input  wire                                rready,
    output logic                               sclk,
    output logic                               ws,
    output logic                               sd,
    output logic                               mute_n
);
    import synth_pkg::*;

    logic                       mute;                     // from control reg
    logic                       sample_tick;              // frame start
    logic signed [sample_w-1:0] chan_sample [num_chan];
    logic signed [sample_w-1:0] left;
    logic signed [sample_w-1:0] right;

    chan_cfg_if u_cfg ();

    axil_regs u_axil_regs (
        .clk     (clk),
        .arst_n  (arst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .mute    (mute),
        .cfg     (u_cfg.regs)
    );

    tone_bank u_tone_bank (
        .clk         (clk),
        .arst_n      (arst_n),
        .sample_tick (sample_tick),
        .cfg         (u_cfg.tone),
        .chan_sample (chan_sample)
    );

    mix_clamp u_mix_clamp (
        .clk         (clk),
        .arst_n      (arst_n),
        .chan_sample (chan_sample),
        .left        (left),
        .right       (right)
    );

    i2s_tx u_i2s_tx (
        .clk         (clk),
        .arst_n      (arst_n),
        .left        (left),
        .right       (right),
        .mute        (mute),
        .sclk        (sclk),
        .ws          (ws),
        .sd          (sd),
        .sample_tick (sample_tick)
    );

    assign mute_n = ~mute;        // codec mute pin, active low

endmodule

`default_nettype wire

// ==== sim/tb_synth.sv ====
`default_nettype none

module tb_synth;
    import bus_pkg::*;

    localparam int bus_timeout   = 100;       // clk cycles per handshake
    localparam int frame_timeout = 600;       // a frame is 256 clks

    logic        clk;
    logic        arst_n;
    logic [7:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        sclk;
    logic        ws;
    logic        sd;
    logic        mute_n;

    integer      seed;                        // $random state
    int          errors;                      // all failed checks
    int          test_err;                    // errors at test start
    int          tests_run;
    int          tests_failed;
    logic [31:0] model [5];                   // chan0..3 then ctrl

    logic [31:0] word_sh;                     // serial bits so far
    logic [31:0] word_nxt;
    logic        ws_d;                        // ws at previous sclk rise
    logic [15:0] left_hold;                   // left word waits for its right
    logic [15:0] cap_left;                    // last full frame
    logic [15:0] cap_right;
    int          frame_cnt;

    synth_top u_synth_top (
        .clk     (clk),
        .arst_n  (arst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .sclk    (sclk),
        .ws      (ws),
        .sd      (sd),
        .mute_n  (mute_n)
    );

    always #10 clk = ~clk;

    assign word_nxt = {word_sh[30:0], sd};

    // ws flips one bit ahead of the msb so that bit still closes the old word
    always @(posedge sclk or negedge arst_n) begin
        if (!arst_n) begin
            word_sh   <= '0;
            ws_d      <= 1'b0;
            left_hold <= '0;
            cap_left  <= '0;
            cap_right <= '0;
            frame_cnt <= 0;
        end else begin
            word_sh <= word_nxt;
            ws_d    <= ws;
            if (ws != ws_d) begin
                if (ws_d) begin                   // right word done and frame complete
                    cap_left  <= left_hold;
                    cap_right <= word_nxt[31:16];
                    frame_cnt <= frame_cnt + 1;
                end else begin
                    left_hold <= word_nxt[31:16]; // sample sits in upper half
                end
            end
        end
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic int rand_below(input int n);
        return int'({$random(seed)} % n);
    endfunction

    function automatic logic [7:0] reg_addr(input int idx);
        case (idx)
            0:       return addr_chan0;
            1:       return addr_chan1;
            2:       return addr_chan2;
            3:       return addr_chan3;
            default: return addr_ctrl;
        endcase
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b])
                res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    function automatic logic [15:0] clamp16(input int s);
        if (s > 32767)
            return 16'h7fff;
        if (s < -32768)
            return 16'h8000;
        return s[15:0];
    endfunction

    // fnum zero keeps phase at 0 and a keyed channel at +amp
    function automatic int static_level(input logic [31:0] w);
        return w[31] ? int'(w[29:15]) : 0;
    endfunction

    function automatic logic [15:0] static_out(input int pair);
        if (model[4][0])
            return 16'h0;                         // muted
        return clamp16(static_level(model[2*pair]) + static_level(model[2*pair+1]));
    endfunction

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("MISMATCH %s: got 0x%h expected 0x%h", what, got, exp);
        errors++;
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        int n;
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        wvalid  <= 1'b1;
        bready  <= 1'b1;
        n = 0;
        @(posedge clk);
        while (!(awready && wready)) begin
            if (n > bus_timeout)
                abort_run("write address and data never accepted");
            @(posedge clk);
            n++;
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        n = 0;
        @(posedge clk);
        while (!bvalid) begin
            if (n > bus_timeout)
                abort_run("write response never arrived");
            @(posedge clk);
            n++;
        end
        resp = bresp;
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= 1'b1;
        n = 0;
        @(posedge clk);
        while (!arready) begin
            if (n > bus_timeout)
                abort_run("read address never accepted");
            @(posedge clk);
            n++;
        end
        arvalid <= 1'b0;
        n = 0;
        @(posedge clk);
        while (!rvalid) begin
            if (n > bus_timeout)
                abort_run("read data never arrived");
            @(posedge clk);
            n++;
        end
        data = rdata;
        resp = rresp;
        rready <= 1'b0;
    endtask

    task automatic wait_frames(input int n);
        int target;
        int cyc;
        repeat (n) begin
            target = frame_cnt + 1;
            cyc = 0;
            while (frame_cnt < target) begin
                if (cyc > frame_timeout)
                    abort_run("no i2s frame captured");
                @(posedge clk);
                cyc++;
            end
        end
    endtask

    task automatic write_reg(input int idx, input logic [31:0] data, input logic [3:0] strb);
        logic [1:0] resp;
        axi_write(reg_addr(idx), data, strb, resp);
        if (resp !== resp_okay)
            report_mismatch("bresp", 32'(resp), 32'(resp_okay));
        model[idx] = merge_bytes(model[idx], data, strb);
    endtask

    task automatic check_reg(input int idx);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(reg_addr(idx), data, resp);
        if (resp !== resp_okay)
            report_mismatch("rresp", 32'(resp), 32'(resp_okay));
        if (data !== model[idx])
            report_mismatch($sformatf("rdata reg %0d", idx), data, model[idx]);
    endtask

    task automatic check_frame(input logic [15:0] exp_l, input logic [15:0] exp_r);
        if (cap_left !== exp_l)
            report_mismatch("left", 32'(cap_left), 32'(exp_l));
        if (cap_right !== exp_r)
            report_mismatch("right", 32'(cap_right), 32'(exp_r));
    endtask

    // key off clears every phase on the next tick
    task automatic silence_all();
        for (int c = 0; c < 4; c++)
            write_reg(c, 32'h0, 4'hf);
        wait_frames(2);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != test_err) begin
            tests_failed++;
            $display("test %0d %s: FAIL, %0d errors", tests_run, name, errors - test_err);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
        test_err = errors;
    endtask

    initial begin
        logic [31:0] w;
        logic [31:0] rd;
        logic [1:0]  resp;
        logic [7:0]  addr;
        int          amp [4];
        int          fnum;
        int          n_pos;
        int          n_neg;
        int          exp_pos;
        int          tol;
        bit          seen_neg;
        clk     = 1'b0;
        arst_n  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        seed    = 15;
        errors  = 0;
        test_err     = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < 4; i++)
            model[i] = '0;
        model[4] = 32'h1;                         // muted out of reset
        repeat (16) @(posedge clk);
        // outputs held low through reset
        check_bit("awready", awready, 1'b0);
        check_bit("wready", wready, 1'b0);
        check_bit("bvalid", bvalid, 1'b0);
        check_bit("arready", arready, 1'b0);
        check_bit("rvalid", rvalid, 1'b0);
        check_bit("sclk", sclk, 1'b0);
        check_bit("ws", ws, 1'b0);
        check_bit("sd", sd, 1'b0);
        check_bit("mute_n", mute_n, 1'b0);
        arst_n <= 1'b1;
        @(posedge clk);

        // reset values then byte-strobed writes
        if (mute_n !== 1'b0)
            report_mismatch("mute_n", 32'(mute_n), 32'h0);
        for (int i = 0; i < 5; i++)
            check_reg(i);
        repeat (20) begin
            w = rand32();
            write_reg(rand_below(5), rand32(), w[3:0]);
            for (int i = 0; i < 5; i++)
                check_reg(i);
        end
        finish_test("register readback");

        repeat (8) begin
            addr = 8'(8'h11 + rand_below(239));       // 0x11..0xff
            axi_write(addr, rand32(), 4'hf, resp);
            if (resp !== resp_slverr)
                report_mismatch("bresp", 32'(resp), 32'(resp_slverr));
            axi_read(addr, rd, resp);
            if (resp !== resp_slverr)
                report_mismatch("rresp", 32'(resp), 32'(resp_slverr));
            if (rd !== 32'h0)
                report_mismatch("rdata", rd, 32'h0);
        end
        for (int i = 0; i < 5; i++)
            check_reg(i);                             // nothing written through
        finish_test("unmapped access");

        write_reg(4, 32'h0, 4'hf);                    // unmute
        silence_all();
        repeat (4) begin
            for (int c = 0; c < 4; c++) begin
                w = rand32();
                w[14:0] = '0;                         // fnum zero
                write_reg(c, w, 4'hf);
            end
            wait_frames(4);
            check_frame(static_out(0), static_out(1));
        end
        finish_test("static levels");

        silence_all();
        for (int c = 0; c < 4; c++) begin
            amp[c] = 16384 + rand_below(16384);       // pair sum above 32767
            write_reg(c, {1'b1, 1'b0, 15'(amp[c]), 15'h0}, 4'hf);
        end
        wait_frames(4);
        check_frame(16'h7fff, 16'h7fff);
        // fast square on ch0 and ch1 so both go negative together
        write_reg(0, {1'b1, 1'b0, 15'(amp[0]), 15'h7fff}, 4'hf);
        write_reg(1, {1'b1, 1'b0, 15'(amp[1]), 15'h7fff}, 4'hf);
        wait_frames(4);
        seen_neg = 1'b0;
        repeat (64) begin
            wait_frames(1);
            if (cap_left == 16'h8000) begin
                seen_neg = 1'b1;
            end else if (cap_left != 16'h7fff && cap_left != 16'(amp[0] - amp[1])
                         && cap_left != 16'(amp[1] - amp[0])) begin
                $display("MISMATCH left: got 0x%h expected one of 0x7fff 0x%h 0x%h 0x8000",
                         cap_left, 16'(amp[0] - amp[1]), 16'(amp[1] - amp[0]));
                errors++;
            end
            if (cap_right !== 16'h7fff)
                report_mismatch("right", 32'(cap_right), 32'h7fff);
        end
        if (!seen_neg) begin
            $display("ERROR: left never clamped to -32768 while both channels were negative");
            errors++;
        end
        finish_test("saturation");

        silence_all();
        w       = rand32();
        amp[0]  = 1 + rand_below(32767);
        fnum    = 24576 + rand_below(8192);           // period 32..43 samples
        write_reg(0, {1'b1, w[0], 15'(amp[0]), 15'(fnum)}, 4'hf);
        wait_frames(4);
        n_pos = 0;
        n_neg = 0;
        repeat (64) begin
            wait_frames(1);
            if (cap_left == 16'(amp[0]))
                n_pos++;
            else if (cap_left == 16'(-amp[0]))
                n_neg++;
            else
                report_mismatch("left", 32'(cap_left), 32'(16'(amp[0])));
            if (cap_right !== 16'h0)
                report_mismatch("right", 32'(cap_right), 32'h0);
        end
        if (n_pos == 0 || n_neg == 0) begin
            $display("ERROR: channel 0 never toggled, %0d high and %0d low", n_pos, n_neg);
            errors++;
        end
        exp_pos = w[0] ? 16 : 32;                     // quarter or half of 64
        tol     = (1 << 20) / fnum / 4 + 4;           // partial period slack
        if (n_pos < exp_pos - tol || n_pos > exp_pos + tol) begin
            $display("ERROR: %0d of 64 samples high, expected %0d within %0d",
                     n_pos, exp_pos, tol);
            errors++;
        end
        finish_test("oscillation");

        write_reg(4, 32'h1, 4'h1);
        if (mute_n !== 1'b0)
            report_mismatch("mute_n", 32'(mute_n), 32'h0);
        for (int c = 0; c < 4; c++)
            write_reg(c, rand32(), 4'hf);             // any setting including a moving phase
        wait_frames(4);
        repeat (4) begin
            wait_frames(1);
            check_frame(16'h0, 16'h0);
        end
        silence_all();
        for (int c = 0; c < 4; c++) begin
            w = rand32();
            w[14:0] = '0;
            write_reg(c, w, 4'hf);
        end
        wait_frames(4);
        check_frame(16'h0, 16'h0);
        write_reg(4, 32'h0, 4'h1);
        if (mute_n !== 1'b1)
            report_mismatch("mute_n", 32'(mute_n), 32'h1);
        wait_frames(4);
        check_frame(static_out(0), static_out(1));
        finish_test("mute");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
logic/bus_pkg.sv
logic/synth_pkg.sv
logic/chan_cfg_if.sv
logic/axil_regs.sv
logic/tone_bank.sv
logic/mix_clamp.sv
logic/i2s_tx.sv
logic/synth_top.sv
sim/tb_synth.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_synth
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= TESTS PASSED

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
